//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = spriteRotTb
FILELIST = spriteRotTop.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | awk '{ print } /^STATUS: PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

//--- cordicRotator.sv
/* pipelined CORDIC rotation of frame points about the centre, with gain
   compensation, rounding to whole pixels and a frame range check */
`default_nettype none
`timescale 1ns/1ns

`include "spriteRot_cfg.svh"

module cordicRotator (
	input wire logic clk,
	input wire logic reset,
	input wire spriteRotPkg::angle_t theta_i,
	input wire logic inValid_i,
	input wire spriteRotPkg::point_t in_i,
	output logic outValid_o,
	output spriteRotPkg::point_t out_o
);
	import spriteRotPkg::*;

	localparam int N = `CORDIC_STAGES;

	// stage[0] is the centred input, stage[k+1] follows iteration k
	cordicStage_t stage [0:N];
	cordicStage_t iterOut [N];
	cordicStage_t centred;
	logic [N:0] valid;

	int pixX;
	int pixY;
	logic inFrame;

	// gain compensation and round half up to an integer
	function automatic int descale(input coord_t c);
		int prod;
		int scaled;
		prod = int'(c) * `CORDIC_GAIN_INV;
		scaled = prod >>> `COORD_FRAC;
		return (scaled + (1 <<< (`COORD_FRAC - 1))) >>> `COORD_FRAC;
	endfunction

	// move origin to frame centre
	always_comb begin
		centred.x = coord_t'((int'(in_i.x) - `X_OFFSET) <<< `COORD_FRAC);
		centred.y = coord_t'((int'(in_i.y) - `Y_OFFSET) <<< `COORD_FRAC);
		centred.z = theta_i;
	end

	for (genvar k = 0; k < N; k++) begin : gIter
		coord_t xShift;
		coord_t yShift;
		logic neg;

		assign xShift = $signed(stage[k].x) >>> k;
		assign yShift = $signed(stage[k].y) >>> k;
		assign neg = stage[k].z[`ANGLE_W-1];

		// drive the residual angle towards zero
		assign iterOut[k].x = neg ? stage[k].x + yShift : stage[k].x - yShift;
		assign iterOut[k].y = neg ? stage[k].y - xShift : stage[k].y + xShift;
		assign iterOut[k].z = neg ? stage[k].z + ATAN_TABLE[k] : stage[k].z - ATAN_TABLE[k];
	end

	always_ff @(posedge clk) begin
		stage[0] <= centred;
		for (int k = 0; k < N; k++)
			stage[k + 1] <= iterOut[k];
	end

	// back to frame coordinates
	assign pixX = descale(stage[N].x) + `X_OFFSET;
	assign pixY = descale(stage[N].y) + `Y_OFFSET;
	assign inFrame = (pixX >= 0) && (pixX < `FRAME_DIM) && (pixY >= 0) && (pixY < `FRAME_DIM);

	always_ff @(posedge clk) begin
		out_o.x <= pixel_t'(pixX);
		out_o.y <= pixel_t'(pixY);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0;
			outValid_o <= 1'b0;
		end else begin
			valid <= {valid[N-1:0], inValid_i};
			// points that land off the frame are dropped here
			outValid_o <= valid[N] && inFrame;
		end
	end

	// an angle inside the table's reach leaves at most one LSB behind
	aResidual: assert property (@(posedge clk) disable iff (reset)
		valid[N] |-> (stage[N].z <= 1) && (stage[N].z >= -1));

endmodule

`default_nettype wire

//--- frameBuffer.sv
/* 57 by 57 bit frame with clear, pixel set and registered line readout */
`default_nettype none
`timescale 1ns/1ns

`include "spriteRot_cfg.svh"

module frameBuffer (
	input wire logic clk,
	input wire logic reset,
	input wire logic clear_i,
	input wire logic plotValid_i,
	input wire spriteRotPkg::point_t plot_i,
	input wire logic [`LINE_ADDR_W-1:0] lineAddr_i,
	output spriteRotPkg::line_t lineData_o
);
	import spriteRotPkg::*;

	// one entry per line, bit x is column x
	line_t frame [`FRAME_DIM];

	always_ff @(posedge clk) begin
		if (reset || clear_i) begin
			for (int i = 0; i < `FRAME_DIM; i++)
				frame[i] <= '0;
		end else if (plotValid_i) begin
			frame[plot_i.y][plot_i.x] <= 1'b1;
		end
	end

	// lines past the frame read as empty
	always_ff @(posedge clk) begin
		if (lineAddr_i < `LINE_ADDR_W'(`FRAME_DIM))
			lineData_o <= frame[lineAddr_i];
		else
			lineData_o <= '0;
	end

	aNoPlotOnClear: assert property (@(posedge clk) disable iff (reset)
		!(clear_i && plotValid_i));

endmodule

`default_nettype wire

//--- spritePointRom.sv
/* sprite block corners and the point stream of one run */
`default_nettype none
`timescale 1ns/1ns

`include "spriteRot_cfg.svh"

module spritePointRom (
	input wire logic clk,
	input wire logic reset,
	input wire logic start_i,
	output logic ptValid_o,
	output spriteRotPkg::point_t pt_o,
	output logic last_o
);
	import spriteRotPkg::*;

	localparam int PER_BLOCK = `POINT_COUNT / `BLOCK_COUNT;
	localparam int OFF_W = $clog2(PER_BLOCK);
	localparam int BLK_W = $clog2(`BLOCK_COUNT);

	// top-left corner of each block, x then y
	localparam point_t CORNERS [`BLOCK_COUNT] = '{
		'{6'd12, 6'd12}, '{6'd40, 6'd12}, '{6'd16, 6'd16}, '{6'd20, 6'd16},
		'{6'd32, 6'd16}, '{6'd36, 6'd16}, '{6'd20, 6'd20}, '{6'd24, 6'd20},
		'{6'd28, 6'd20}, '{6'd32, 6'd20}, '{6'd16, 6'd24}, '{6'd20, 6'd24},
		'{6'd32, 6'd24}, '{6'd36, 6'd24}, '{6'd20, 6'd28}, '{6'd32, 6'd28},
		'{6'd16, 6'd32}, '{6'd20, 6'd32}, '{6'd32, 6'd32}, '{6'd36, 6'd32},
		'{6'd20, 6'd36}, '{6'd24, 6'd36}, '{6'd28, 6'd36}, '{6'd32, 6'd36},
		'{6'd16, 6'd40}, '{6'd36, 6'd40}
	};

	logic [BLK_W-1:0] blk;
	logic [OFF_W-1:0] off;

	// column steps slowest inside a block, row fastest
	always_comb begin
		pt_o.x = CORNERS[blk].x + pixel_t'(off / `BLOCK_SIDE);
		pt_o.y = CORNERS[blk].y + pixel_t'(off % `BLOCK_SIDE);
	end

	assign last_o = ptValid_o && (blk == BLK_W'(`BLOCK_COUNT - 1))
		&& (off == OFF_W'(PER_BLOCK - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			ptValid_o <= 1'b0;
			blk <= '0;
			off <= '0;
		end else if (start_i) begin
			ptValid_o <= 1'b1;
			blk <= '0;
			off <= '0;
		end else if (ptValid_o) begin
			if (last_o) begin
				ptValid_o <= 1'b0;
			end else begin
				off <= off + 1'b1;
				if (off == OFF_W'(PER_BLOCK - 1))
					blk <= blk + 1'b1;
			end
		end
	end

	aNoRestart: assert property (@(posedge clk) disable iff (reset)
		start_i |-> !ptValid_o);

endmodule

`default_nettype wire

//--- spriteRotPkg.sv
/* pixel, point, coordinate, angle and line types plus the CORDIC arctangent table */
`default_nettype none

`include "spriteRot_cfg.svh"

package spriteRotPkg;

	typedef logic [`PIX_W-1:0] pixel_t;

	typedef struct packed {
		pixel_t x;
		pixel_t y;
	} point_t;

	typedef logic signed [`COORD_W-1:0] coord_t;
	typedef logic signed [`ANGLE_W-1:0] angle_t;
	typedef logic [`FRAME_DIM-1:0] line_t;

	// one CORDIC stage result
	typedef struct packed {
		coord_t x;
		coord_t y;
		angle_t z;
	} cordicStage_t;

	// atan(2^-k) with 10 fraction bits
	localparam angle_t ATAN_TABLE [`CORDIC_STAGES] = '{
		13'sd804, 13'sd475, 13'sd251, 13'sd127,
		13'sd64, 13'sd32, 13'sd16, 13'sd8,
		13'sd4, 13'sd2, 13'sd1, 13'sd0
	};

endpackage

`default_nettype wire

//--- spriteRotTb.sv
/* testbench of the sprite rotator: runs from the golden file, shuffled line
   readout, start handshake checks and a watchdog */
`default_nettype none
`timescale 1ns/1ns

`include "spriteRot_cfg.svh"

module spriteRotTb;
	import spriteRotPkg::*;

	localparam int WAIT_LIMIT = 1000;

	logic clk;
	logic reset;
	logic startValid;
	angle_t theta;
	logic startReady;
	logic [`LINE_ADDR_W-1:0] lineAddr;
	line_t lineData;
	logic done;

	int numTests;
	logic [31:0] rngState;
	line_t expLines [`FRAME_DIM];

	tbClock #(.PERIOD(40), .RESET_CYCLES(5)) clkGen (.clk_o(clk), .reset_o(reset));

	spriteRotTop dut_i (
		.clk(clk),
		.reset(reset),
		.startValid_i(startValid),
		.theta_i(theta),
		.startReady_o(startReady),
		.lineAddr_i(lineAddr),
		.lineData_o(lineData),
		.done_o(done)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] r;
		r = s ^ (s << 13);
		r = r ^ (r >> 17);
		return r ^ (r << 5);
	endfunction

	task automatic pickRandom(input int limit, output int value);
		rngState = xorshift32(rngState);
		value = int'(rngState % 32'(limit));
	endtask

	task automatic stopWithFailure();
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic compare(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("Mismatch at %0t ns: %s, got %h, expected %h",
				$time, what, actual, expected);
			stopWithFailure();
		end
	endtask

	task automatic checkWait(input int waited, input string what);
		if (waited >= WAIT_LIMIT) begin
			$display("Timed out waiting for %s", what);
			stopWithFailure();
		end
	endtask

	// every line once, in shuffled order
	task automatic checkFrame(input string tag);
		int order [`FRAME_DIM];
		int j;
		int tmp;
		for (int i = 0; i < `FRAME_DIM; i++)
			order[i] = i;
		for (int i = `FRAME_DIM - 1; i > 0; i--) begin
			pickRandom(i + 1, j);
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 0; i < `FRAME_DIM; i++) begin
			lineAddr = `LINE_ADDR_W'(order[i]);
			// data is registered, so it shows one cycle later
			@(negedge clk);
			compare(64'(lineData), 64'(expLines[order[i]]),
				$sformatf("%s line %0d", tag, order[i]));
		end
	endtask

	// angle, then (count, line) runs that cover lines 0 to 56
	task automatic readTest(input int fd, input int idx, output angle_t angle);
		int angleVal;
		int count;
		int filled;
		logic [63:0] value;
		if ($fscanf(fd, " %d", angleVal) != 1) begin
			$display("Golden file has no angle for test %0d", idx);
			stopWithFailure();
		end
		angle = angle_t'(angleVal);
		filled = 0;
		while (filled < `FRAME_DIM) begin
			if ($fscanf(fd, " %d %h", count, value) != 2 || count < 1
					|| filled + count > `FRAME_DIM) begin
				$display("Golden file has a bad line run in test %0d", idx);
				stopWithFailure();
			end
			repeat (count) begin
				expLines[filled] = line_t'(value);
				filled++;
			end
		end
	endtask

	task automatic runTest(input int idx, input angle_t angle);
		int gap;
		int waited;
		pickRandom(8, gap);
		repeat (gap) @(negedge clk);
		waited = 0;
		while (!startReady) begin
			checkWait(waited, $sformatf("startReady_o before test %0d", idx));
			waited++;
			@(negedge clk);
		end
		startValid = 1'b1;
		theta = angle;
		@(negedge clk);
		waited = 0;
		while (!done) begin
			// stray start while busy must be ignored
			startValid = (waited == 40);
			theta = angle_t'(~angle);
			compare(64'(startReady), 64'd0, $sformatf("startReady_o busy in test %0d", idx));
			checkWait(waited, $sformatf("done_o in test %0d", idx));
			waited++;
			@(negedge clk);
		end
		startValid = 1'b0;
		compare(64'(startReady), 64'd1, $sformatf("startReady_o at done in test %0d", idx));
	endtask

	initial begin
		int fd;
		logic [8*128-1:0] header;
		angle_t angle;
		startValid = 1'b0;
		theta = '0;
		lineAddr = '0;
		rngState = 32'heef1_2481;
		numTests = 0;
		fd = $fopen("spriteRot_golden.txt", "r");
		if (fd == 0) begin
			$display("Cannot open spriteRot_golden.txt");
			stopWithFailure();
		end
		// two lines of column description
		if ($fgets(header, fd) == 0 || $fgets(header, fd) == 0) begin
			$display("Golden file has no column description");
			stopWithFailure();
		end
		if ($fscanf(fd, " %d", numTests) != 1) begin
			$display("Golden file has no test count");
			stopWithFailure();
		end

		@(negedge clk);
		while (reset !== 1'b0)
			@(negedge clk);
		compare(64'(startReady), 64'd1, "startReady_o after reset");
		compare(64'(done), 64'd0, "done_o after reset");
		for (int i = 0; i < `FRAME_DIM; i++)
			expLines[i] = '0;
		checkFrame("after reset");

		for (int t = 0; t < numTests; t++) begin
			readTest(fd, t, angle);
			runTest(t, angle);
			checkFrame($sformatf("test %0d angle %0d", t, angle));
		end
		$fclose(fd);
		$display("STATUS: PASS");
		$finish;
	end

	// generous bound per run, roughly 500 cycles each
	initial begin
		wait (numTests > 0);
		repeat (numTests * 600 + 200) @(posedge clk);
		$display("Watchdog expired after %0d cycles", numTests * 600 + 200);
		stopWithFailure();
	end

endmodule

`default_nettype wire

//--- spriteRotTop.f
+incdir+.
spriteRotPkg.sv
spritePointRom.sv
cordicRotator.sv
frameBuffer.sv
spriteRotTop.sv
tbClock.sv
spriteRotTb.sv

//--- spriteRotTop.sv
/* sprite rotator top level with start handshake, done flag, point ROM,
   CORDIC pipeline and frame buffer */
`default_nettype none
`timescale 1ns/1ns

`include "spriteRot_cfg.svh"

module spriteRotTop (
	input wire logic clk,
	input wire logic reset,
	input wire logic startValid_i,
	input wire spriteRotPkg::angle_t theta_i,
	output logic startReady_o,
	input wire logic [`LINE_ADDR_W-1:0] lineAddr_i,
	output spriteRotPkg::line_t lineData_o,
	output logic done_o
);
	import spriteRotPkg::*;

	localparam int PIPE_DEPTH = `CORDIC_STAGES + 2;

	logic busy;
	logic accept;
	logic streamDone;
	angle_t theta;

	logic ptValid;
	logic ptLast;
	point_t pt;
	logic outValid;
	point_t plotPt;

	logic [$clog2(PIPE_DEPTH + 1)-1:0] inFlight;
	logic [$clog2(PIPE_DEPTH + 1)-1:0] inFlightNext;
	logic leave;

	assign startReady_o = !busy;
	assign accept = startValid_i && startReady_o;

	// oldest point exits when the gap-free pipe is full or draining
	assign leave = (inFlight == PIPE_DEPTH) || (streamDone && inFlight != 0);

	always_comb begin
		inFlightNext = inFlight;
		if (ptValid && !leave)
			inFlightNext = inFlight + 1'b1;
		else if (!ptValid && leave)
			inFlightNext = inFlight - 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			done_o <= 1'b0;
			streamDone <= 1'b0;
			inFlight <= '0;
		end else begin
			inFlight <= inFlightNext;
			if (accept) begin
				busy <= 1'b1;
				done_o <= 1'b0;
				streamDone <= 1'b0;
			end else if (busy) begin
				if (ptLast)
					streamDone <= 1'b1;
				if (streamDone && inFlightNext == 0) begin
					busy <= 1'b0;
					done_o <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			theta <= theta_i;
	end

	spritePointRom pointRom (
		.clk(clk),
		.reset(reset),
		.start_i(accept),
		.ptValid_o(ptValid),
		.pt_o(pt),
		.last_o(ptLast)
	);

	cordicRotator rotator (
		.clk(clk),
		.reset(reset),
		.theta_i(theta),
		.inValid_i(ptValid),
		.in_i(pt),
		.outValid_o(outValid),
		.out_o(plotPt)
	);

	// accept cycle wipes the previous image
	frameBuffer frame (
		.clk(clk),
		.reset(reset),
		.clear_i(accept),
		.plotValid_i(outValid),
		.plot_i(plotPt),
		.lineAddr_i(lineAddr_i),
		.lineData_o(lineData_o)
	);

	// a point leaving the rotator is still counted in flight
	aExitCounted: assert property (@(posedge clk) disable iff (reset)
		outValid |-> inFlight != 0);

endmodule

`default_nettype wire

//--- spriteRot_cfg.svh
/* frame geometry, sprite counts and fixed-point settings of the sprite rotator */
`ifndef SPRITEROT_CFG_SVH
`define SPRITEROT_CFG_SVH

// frame and readout
`define FRAME_DIM 57
`define LINE_ADDR_W 6
`define PIX_W 6

// sprite made of square blocks
`define BLOCK_COUNT 26
`define BLOCK_SIDE 4
`define POINT_COUNT 416

// angle carries 10 fraction bits
`define ANGLE_W 13
`define COORD_W 16
`define COORD_FRAC 8

`define CORDIC_STAGES 12
`define X_OFFSET 27
`define Y_OFFSET 29
// 0.607253 with 8 fraction bits
`define CORDIC_GAIN_INV 155

`endif

//--- spriteRot_golden.txt
# test count, then per test an angle in radians with 10 fraction bits
# followed by (repeat count, hex line) pairs for lines 0 to 56, bit n is column n
7
0     12 0 4 F000000F000 4 FF00FF0000 4 FFFF00000 4 FF00FF0000
      4 F00F00000 4 FF00FF0000 4 FFFF00000 4 F0000F0000 13 0
1608  14 0 4 1E0000000000 4 1E1E1E1E000 4 1FFFFFE0000 8 1E001E0000
      4 1FFFFFE0000 4 1E1E1E1E000 4 1E0000000000 11 0
-1608 13 0 4 3C00 4 3C3C3C3C000 4 3FFFFFC000 8 3C003C0000
      4 3FFFFFC000 4 3C3C3C3C000 4 3C00 12 0
5     12 0 4 F000000F000 4 FF00FF0000 4 FFFF00000 4 FF00FF0000
      4 F00F00000 4 FF00FF0000 4 FFFF00000 4 F0000F0000 13 0
1602  14 0 4 1E0000000000 4 1E1E1E1E000 4 1FFFFFE0000 8 1E001E0000
      4 1FFFFFE0000 4 1E1E1E1E000 4 1E0000000000 11 0
-6    12 0 4 F000000F000 4 FF00FF0000 4 FFFF00000 4 FF00FF0000
      4 F00F00000 4 FF00FF0000 4 FFFF00000 4 F0000F0000 13 0
-1614 13 0 4 3C00 4 3C3C3C3C000 4 3FFFFFC000 8 3C003C0000
      4 3FFFFFC000 4 3C3C3C3C000 4 3C00 12 0

//--- tbClock.sv
/* clock and reset generator for the testbench */
`default_nettype none
`timescale 1ns/1ns

module tbClock #(
	parameter int PERIOD = 40,
	parameter int RESET_CYCLES = 5
) (
	output logic clk_o,
	output logic reset_o
);
	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2) clk_o = ~clk_o;
	end

	// reset released after a few rising edges
	initial begin
		reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		reset_o <= 1'b0;
	end

endmodule

`default_nettype wire
